// ==== pool_geom_pkg.sv ====
//----------------------------------------------------------------------------
// table geometry shared by the video side and the game core
// pocket bit order is fixed and sets the level-1 target order
//----------------------------------------------------------------------------
`default_nettype none

package pool_geom_pkg;

	localparam int unsigned NUM_HOLES = 6;

	// bit 0 right-bottom, 1 left-top, 2 middle-bottom
	// bit 3 right-top, 4 left-bottom, 5 middle-top
	typedef logic [NUM_HOLES-1:0] hole_vec_t;

	// drawing requests of one pixel
	typedef struct packed {
		logic      white;
		logic      red;
		logic      black;
		hole_vec_t holes;
	} draw_req_t;

	// hit events of one cycle, carried by a single-cycle valid
	typedef struct packed {
		hole_vec_t red_holes;  // pockets the red ball overlaps
		logic      white_hit;
		logic      black_hit;
		logic      valid;
	} hole_hit_t;

endpackage

`default_nettype wire

// ==== pool_rules_pkg.sv ====
//----------------------------------------------------------------------------
// game rules: phases, the sign and magnitude score and the level goals
// goals must stay below SCORE_MAX or the level can never end
//----------------------------------------------------------------------------
`default_nettype none

package pool_rules_pkg;

	typedef enum logic [2:0] {
		PH_OPEN   = 3'd0,
		PH_LEVEL1 = 3'd1,
		PH_LEVEL2 = 3'd2,
		PH_LEVEL3 = 3'd3,
		PH_WINNER = 3'd4,
		PH_LOSER  = 3'd5
	} phase_t;

	// score as sign and magnitude
	typedef struct packed {
		logic       neg;
		logic [3:0] mag;
	} score_t;

	localparam logic [3:0] SCORE_MAX = 4'd15;

	// points needed to leave each level
	localparam logic [3:0] GOAL_L1 = 4'd2;
	localparam logic [3:0] GOAL_L2 = 4'd2;
	localparam logic [3:0] GOAL_L3 = 4'd3;

	// first target pocket, index into hole_vec_t
	localparam int unsigned FIRST_TARGET = 0;

endpackage

`default_nettype wire

// ==== hole_hit_detector.sv ====
//----------------------------------------------------------------------------
// ball-in-pocket detection, each ball reported at most once per frame
// an overlap on the start_of_frame cycle already counts for the new frame
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hole_hit_detector
	import pool_geom_pkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  logic      start_of_frame,
	input  draw_req_t draw_req,
	output hole_hit_t hits
);

	hole_vec_t red_over;   // pockets under the red pixel
	logic      any_hole;
	logic      red_ov;
	logic      white_ov;
	logic      black_ov;
	logic      red_done;   // reported in this frame
	logic      white_done;
	logic      black_done;
	logic      red_new;
	logic      white_new;
	logic      black_new;

	// pixel overlaps
	always_comb begin
		any_hole = |draw_req.holes;
		red_over = draw_req.red ? draw_req.holes : '0;
		red_ov   = draw_req.red & any_hole;
		white_ov = draw_req.white & any_hole;
		black_ov = draw_req.black & any_hole;
	end

	// first overlap only, the old frame's flags drop at start_of_frame
	assign red_new   = red_ov & ~(red_done & ~start_of_frame);
	assign white_new = white_ov & ~(white_done & ~start_of_frame);
	assign black_new = black_ov & ~(black_done & ~start_of_frame);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			red_done   <= 1'b0;
			white_done <= 1'b0;
			black_done <= 1'b0;
			hits       <= '0;
		end else begin
			red_done   <= (red_done & ~start_of_frame) | red_new;
			white_done <= (white_done & ~start_of_frame) | white_new;
			black_done <= (black_done & ~start_of_frame) | black_new;

			hits.red_holes <= red_new ? red_over : '0;
			hits.white_hit <= white_new;
			hits.black_hit <= black_new;
			hits.valid     <= red_new | white_new | black_new;  // one-cycle strobe
		end
	end

endmodule

`default_nettype wire

// ==== game_phase_fsm.sv ====
//----------------------------------------------------------------------------
// screen and level sequencing, enter is sampled as a level
// holding enter over two edges passes straight through the open screen
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module game_phase_fsm
	import pool_geom_pkg::*;
	import pool_rules_pkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  logic      enter,
	input  hole_hit_t hits,
	input  logic      goal_reached,
	output phase_t    phase,
	output logic      open_screen,
	output logic      winner_screen,
	output logic      loser_screen,
	output logic      black_enable
);

	phase_t state;
	phase_t state_nxt;
	logic   black_hit;

	assign black_hit = hits.valid & hits.black_hit;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= PH_OPEN;
		end else begin
			state <= state_nxt;
		end
	end

	// ------------------------------------------------------------------------
	// next phase
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			PH_OPEN: begin
				if (enter) state_nxt = PH_LEVEL1;
			end
			PH_LEVEL1: begin
				if (goal_reached) state_nxt = PH_LEVEL2;
			end
			PH_LEVEL2: begin
				if (goal_reached) state_nxt = PH_LEVEL3;
			end
			PH_LEVEL3: begin
				if (black_hit) begin
					state_nxt = PH_LOSER;   // black ball wins over the goal
				end else if (goal_reached) begin
					state_nxt = PH_WINNER;
				end
			end
			PH_WINNER, PH_LOSER: begin
				if (enter) state_nxt = PH_OPEN;
			end
			default: state_nxt = PH_OPEN;
		endcase
	end

	assign phase         = state;
	assign open_screen   = (state == PH_OPEN);
	assign winner_screen = (state == PH_WINNER);
	assign loser_screen  = (state == PH_LOSER);
	assign black_enable  = (state == PH_LEVEL3);

endmodule

`default_nettype wire

// ==== score_keeper.sv ====
//----------------------------------------------------------------------------
// signed score and level-1 target, one update per hit strobe
// a red overlap in the strobe masks a white overlap in the same strobe
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module score_keeper
	import pool_geom_pkg::*;
	import pool_rules_pkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  hole_hit_t hits,
	input  phase_t    phase,
	output score_t    score,
	output hole_vec_t target,
	output logic      goal_reached
);

	hole_vec_t  tgt_q;       // held through all phases, shown in level 1
	hole_vec_t  tgt_first;
	logic [3:0] goal;
	logic       in_level;
	logic       red_any;
	logic       red_scores;

	// one step toward plus, saturating
	function automatic score_t score_up(score_t s);
		score_t r;
		r = s;
		if (s.neg) begin
			r.mag = s.mag - 4'd1;
			r.neg = (r.mag != 4'd0);   // back to plus at zero
		end else if (s.mag != SCORE_MAX) begin
			r.mag = s.mag + 4'd1;
		end
		return r;
	endfunction

	// one step toward minus, saturating
	function automatic score_t score_down(score_t s);
		score_t r;
		r = s;
		if (!s.neg && s.mag == 4'd0) begin
			r.neg = 1'b1;
			r.mag = 4'd1;
		end else if (!s.neg) begin
			r.mag = s.mag - 4'd1;
		end else if (s.mag != SCORE_MAX) begin
			r.mag = s.mag + 4'd1;
		end
		return r;
	endfunction

	// goal of the current level
	always_comb begin
		in_level = 1'b1;
		case (phase)
			PH_LEVEL1: goal = GOAL_L1;
			PH_LEVEL2: goal = GOAL_L2;
			PH_LEVEL3: goal = GOAL_L3;
			default: begin
				goal     = 4'd0;
				in_level = 1'b0;
			end
		endcase
	end

	assign goal_reached = in_level & ~score.neg & (score.mag == goal);

	assign tgt_first  = hole_vec_t'(1) << FIRST_TARGET;
	assign red_any    = |hits.red_holes;
	assign red_scores = (phase == PH_LEVEL1) ? |(hits.red_holes & tgt_q) : red_any;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			score <= '0;
			tgt_q <= tgt_first;
		end else if (!in_level || goal_reached) begin
			score <= '0;          // screens and level change start from zero
			tgt_q <= tgt_first;
		end else if (hits.valid) begin
			if (red_any) begin
				if (red_scores) begin
					score <= score_up(score);
					if (phase == PH_LEVEL1) tgt_q <= {tgt_q[NUM_HOLES-2:0], tgt_q[NUM_HOLES-1]};
				end
			end else if (hits.white_hit) begin
				score <= score_down(score);  // target stays
			end
		end
	end

	assign target = (phase == PH_LEVEL1) ? tgt_q : '0;

endmodule

`default_nettype wire

// ==== pool_game_top.sv ====
//----------------------------------------------------------------------------
// scoring and level core of the pool game
// pixel to score is 2 cycles and goal to level change 1 more
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pool_game_top
	import pool_geom_pkg::*;
	import pool_rules_pkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  logic      start_of_frame,
	input  draw_req_t draw_req,
	input  logic      enter,
	output phase_t    phase,
	output score_t    score,
	output hole_vec_t target,
	output logic      black_enable,
	output logic      open_screen,
	output logic      winner_screen,
	output logic      loser_screen
);

	hole_hit_t hits;          // strobe to both sides
	logic      goal_reached;  // level goal met, back to the FSM

	hole_hit_detector u_hole_hit_detector (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.draw_req       (draw_req),
		.hits           (hits)
	);

	game_phase_fsm u_game_phase_fsm (
		.clk           (clk),
		.resetN        (resetN),
		.enter         (enter),
		.hits          (hits),
		.goal_reached  (goal_reached),
		.phase         (phase),
		.open_screen   (open_screen),
		.winner_screen (winner_screen),
		.loser_screen  (loser_screen),
		.black_enable  (black_enable)
	);

	score_keeper u_score_keeper (
		.clk          (clk),
		.resetN       (resetN),
		.hits         (hits),
		.phase        (phase),
		.score        (score),
		.target       (target),
		.goal_reached (goal_reached)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
//----------------------------------------------------------------------------
// testbench clock of 4 ns, reset held low over the first 3 rising edges
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic resetN
);

	initial begin
		clk    = 1'b0;
		resetN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;   // released away from the rising edge
	end

	always #2 clk = ~clk;   // half period

endmodule

`default_nettype wire

// ==== pool_game_asserts.sv ====
//----------------------------------------------------------------------------
// score keeper properties, bound into every score_keeper instance
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pool_game_asserts
	import pool_geom_pkg::*;
	import pool_rules_pkg::*;
(
	input logic      clk,
	input logic      resetN,
	input hole_hit_t hits,
	input phase_t    phase,
	input score_t    score,
	input hole_vec_t target,
	input logic      goal_reached
);

	logic screen_phase;   // score is forced to zero here

	assign screen_phase = !(phase inside {PH_LEVEL1, PH_LEVEL2, PH_LEVEL3});

	// no minus zero
	neg_has_mag: assert property (@(posedge clk) disable iff (!resetN)
		score.neg |-> (score.mag != 4'd0))
		else $error("score is negative with a zero magnitude");

	target_onehot: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(target))
		else $error("target has more than one pocket set");

	// updates come from a strobe, a goal or a screen clear
	score_cause: assert property (@(posedge clk) disable iff (!resetN)
		(score != $past(score)) |->
			($past(hits.valid) || $past(goal_reached) || $past(screen_phase)))
		else $error("score changed without a hit, a goal or a screen");

endmodule

bind score_keeper pool_game_asserts u_pool_game_asserts (
	.clk          (clk),
	.resetN       (resetN),
	.hits         (hits),
	.phase        (phase),
	.score        (score),
	.target       (target),
	.goal_reached (goal_reached)
);

`default_nettype wire

// ==== tb_pool_game.sv ====
//----------------------------------------------------------------------------
// one table row per frame, inputs change on the falling edge
// each row is checked 4 idle cycles after its last ball pixel
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_pool_game
	import pool_geom_pkg::*;
	import pool_rules_pkg::*;
();

	typedef struct packed {
		draw_req_t  req;
		logic [2:0] cycles;      // pixels with req held, 1 to 4
		logic       enter;       // pulsed with start_of_frame
		phase_t     exp_phase;
		logic       exp_neg;
		logic [3:0] exp_mag;
		hole_vec_t  exp_target;
	} frame_row_t;

	logic       clk;
	logic       resetN;
	logic       start_of_frame;
	draw_req_t  draw_req;
	logic       enter;
	phase_t     phase;
	score_t     score;
	hole_vec_t  target;
	logic       black_enable;
	logic       open_screen;
	logic       winner_screen;
	logic       loser_screen;

	frame_row_t frame_rows[$];
	integer     seed;
	int         errors;
	int         rows_done;
	int         cycle_cnt = 0;
	int         cycle_limit = 0;   // zero until the table is known

	tb_clock_gen u_tb_clock_gen (
		.clk    (clk),
		.resetN (resetN)
	);

	pool_game_top u_pool_game_top (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.draw_req       (draw_req),
		.enter          (enter),
		.phase          (phase),
		.score          (score),
		.target         (target),
		.black_enable   (black_enable),
		.open_screen    (open_screen),
		.winner_screen  (winner_screen),
		.loser_screen   (loser_screen)
	);

	// balls are {white, red, black}
	function automatic draw_req_t pixel_req(input logic [2:0] balls, input hole_vec_t holes);
		return {balls, holes};
	endfunction

	// pockets only, no ball
	function draw_req_t filler_req();
		draw_req_t r;
		r       = '0;
		r.holes = hole_vec_t'($random(seed));
		return r;
	endfunction

	task add_row(input draw_req_t req, input logic [2:0] cycles, input logic ent,
			input phase_t ph, input logic neg, input logic [3:0] mag, input hole_vec_t tgt);
		frame_row_t r;
		r.req        = req;
		r.cycles     = cycles;
		r.enter      = ent;
		r.exp_phase  = ph;
		r.exp_neg    = neg;
		r.exp_mag    = mag;
		r.exp_target = tgt;
		frame_rows.push_back(r);
	endtask

	task drive_cycle(input logic sof, input logic ent, input draw_req_t req);
		@(negedge clk);
		start_of_frame = sof;
		enter          = ent;
		draw_req       = req;
	endtask

	task run_frame(input frame_row_t row);
		drive_cycle(1'b1, row.enter, filler_req());
		repeat (row.cycles) drive_cycle(1'b0, 1'b0, row.req);
		repeat (4) drive_cycle(1'b0, 1'b0, filler_req());
		@(negedge clk);
	endtask

	task check_row(input int idx, input frame_row_t row);
		logic exp_open;
		logic exp_winner;
		logic exp_loser;
		logic exp_black;
		exp_open   = (row.exp_phase == PH_OPEN);
		exp_winner = (row.exp_phase == PH_WINNER);
		exp_loser  = (row.exp_phase == PH_LOSER);
		exp_black  = (row.exp_phase == PH_LEVEL3);
		if (phase !== row.exp_phase) begin
			$display("MISMATCH row %0d phase: got %h expected %h", idx, phase, row.exp_phase);
			errors++;
		end
		if (score.neg !== row.exp_neg) begin
			$display("MISMATCH row %0d score.neg: got %h expected %h", idx, score.neg, row.exp_neg);
			errors++;
		end
		if (score.mag !== row.exp_mag) begin
			$display("MISMATCH row %0d score.mag: got %h expected %h", idx, score.mag, row.exp_mag);
			errors++;
		end
		if (target !== row.exp_target) begin
			$display("MISMATCH row %0d target: got %h expected %h", idx, target, row.exp_target);
			errors++;
		end
		if (open_screen !== exp_open) begin
			$display("MISMATCH row %0d open_screen: got %h expected %h", idx, open_screen, exp_open);
			errors++;
		end
		if (winner_screen !== exp_winner) begin
			$display("MISMATCH row %0d winner_screen: got %h expected %h", idx, winner_screen,
				exp_winner);
			errors++;
		end
		if (loser_screen !== exp_loser) begin
			$display("MISMATCH row %0d loser_screen: got %h expected %h", idx, loser_screen, exp_loser);
			errors++;
		end
		if (black_enable !== exp_black) begin
			$display("MISMATCH row %0d black_enable: got %h expected %h", idx, black_enable, exp_black);
			errors++;
		end
		rows_done++;
	endtask

	// ------------------------------------------------------------------------
	// frame table and run
	// ------------------------------------------------------------------------
	initial begin
		start_of_frame = 1'b0;
		enter          = 1'b0;
		draw_req       = '0;
		seed           = 32;
		errors         = 0;
		rows_done      = 0;

		// req, cycles, enter, phase, neg, mag, target
		add_row(pixel_req(3'b000, 6'b000000), 3'd1, 1'b0, PH_OPEN, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b000, 6'b000000), 3'd1, 1'b1, PH_LEVEL1, 1'b0, 4'd0, 6'b000001);
		add_row(pixel_req(3'b100, 6'b000100), 3'd3, 1'b0, PH_LEVEL1, 1'b1, 4'd1, 6'b000001);
		add_row(pixel_req(3'b010, 6'b000001), 3'd4, 1'b0, PH_LEVEL1, 1'b0, 4'd0, 6'b000010);
		add_row(pixel_req(3'b010, 6'b010000), 3'd2, 1'b0, PH_LEVEL1, 1'b0, 4'd0, 6'b000010);
		add_row(pixel_req(3'b010, 6'b000010), 3'd4, 1'b0, PH_LEVEL1, 1'b0, 4'd1, 6'b000100);
		add_row(pixel_req(3'b110, 6'b000100), 3'd2, 1'b0, PH_LEVEL2, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b010, 6'b100000), 3'd2, 1'b0, PH_LEVEL2, 1'b0, 4'd1, 6'b000000);
		add_row(pixel_req(3'b001, 6'b000010), 3'd2, 1'b0, PH_LEVEL2, 1'b0, 4'd1, 6'b000000);
		add_row(pixel_req(3'b010, 6'b001000), 3'd1, 1'b0, PH_LEVEL3, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b010, 6'b000001), 3'd1, 1'b0, PH_LEVEL3, 1'b0, 4'd1, 6'b000000);
		add_row(pixel_req(3'b001, 6'b000010), 3'd3, 1'b0, PH_LOSER, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b000, 6'b000000), 3'd1, 1'b1, PH_OPEN, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b000, 6'b000000), 3'd1, 1'b1, PH_LEVEL1, 1'b0, 4'd0, 6'b000001);
		add_row(pixel_req(3'b010, 6'b000001), 3'd2, 1'b0, PH_LEVEL1, 1'b0, 4'd1, 6'b000010);
		add_row(pixel_req(3'b010, 6'b000010), 3'd2, 1'b0, PH_LEVEL2, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b010, 6'b010000), 3'd1, 1'b0, PH_LEVEL2, 1'b0, 4'd1, 6'b000000);
		add_row(pixel_req(3'b010, 6'b000001), 3'd1, 1'b0, PH_LEVEL3, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b010, 6'b000100), 3'd1, 1'b0, PH_LEVEL3, 1'b0, 4'd1, 6'b000000);
		add_row(pixel_req(3'b010, 6'b100000), 3'd3, 1'b0, PH_LEVEL3, 1'b0, 4'd2, 6'b000000);
		add_row(pixel_req(3'b010, 6'b001000), 3'd1, 1'b0, PH_WINNER, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b010, 6'b000001), 3'd2, 1'b0, PH_WINNER, 1'b0, 4'd0, 6'b000000);
		add_row(pixel_req(3'b000, 6'b000000), 3'd1, 1'b1, PH_OPEN, 1'b0, 4'd0, 6'b000000);

		// reset, each frame's cycles and some margin
		cycle_limit = 3 + 40;
		foreach (frame_rows[i]) cycle_limit = cycle_limit + int'(frame_rows[i].cycles) + 6;

		wait (resetN === 1'b1);
		for (int i = 0; i < frame_rows.size(); i++) begin
			run_frame(frame_rows[i]);
			check_row(i, frame_rows[i]);
		end

		$display("rows checked %0d, errors %0d", rows_done, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("timeout, frame table not done after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
pool_geom_pkg.sv
pool_rules_pkg.sv
hole_hit_detector.sv
game_phase_fsm.sv
score_keeper.sv
pool_game_top.sv
tb_clock_gen.sv
pool_game_asserts.sv
tb_pool_game.sv

// ==== Makefile ====
# Verilator build and run of the pool game testbench

VERILATOR ?= verilator
TOP       ?= tb_pool_game
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
